//--- hdl/cop_isa_pkg.sv
package cop_isa_pkg;

    // Instruction word
    localparam int instr_w = 32;

    // Field positions, LSB first
    localparam int class_lsb    = 0;
    localparam int class_w      = 4;
    localparam int subclass_lsb = 4;
    localparam int subclass_w   = 5;
    localparam int rd_lsb       = 9;   // Destination index
    localparam int rs1_lsb      = 13;
    localparam int rs2_lsb      = 17;

    // Register file shape, fixed by the 4-bit index fields
    localparam int reg_idx_w = 4;
    localparam int reg_count = 16;

    // Only the AES class is executed here
    localparam logic [class_w-1:0] class_aes = 4'b0101;

    // AES subclasses
    // SubBytes, sources interleaved from rs1 and rs2
    localparam logic [subclass_w-1:0] sclass_sub_enc    = 5'b00001;
    localparam logic [subclass_w-1:0] sclass_sub_encrot = 5'b00010;
    localparam logic [subclass_w-1:0] sclass_sub_dec    = 5'b00011;
    localparam logic [subclass_w-1:0] sclass_sub_decrot = 5'b00100;

    // MixColumns, one column split over rs1 low half and rs2 high half
    localparam logic [subclass_w-1:0] sclass_mix_enc    = 5'b00101;
    localparam logic [subclass_w-1:0] sclass_mix_dec    = 5'b00110;

    // Subclass code 0 and codes above 6 are unused and decode as illegal

endpackage

//--- hdl/aes_pkg.sv
package aes_pkg;

    localparam int data_w = 32;

    // x^8 = x^4 + x^3 + x + 1
    localparam logic [7:0] gf_poly       = 8'h1b;
    localparam logic [7:0] sbox_affine_c = 8'h63;

    // Inverse MixColumns row, rotated once per output byte
    localparam logic [3:0] mix_inv_c0 = 4'he;
    localparam logic [3:0] mix_inv_c1 = 4'hb;
    localparam logic [3:0] mix_inv_c2 = 4'hd;
    localparam logic [3:0] mix_inv_c3 = 4'h9;

    // Multiply by x
    function automatic logic [7:0] gf_xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? gf_poly : 8'h00);
    endfunction

    // Shift-and-add product in GF(2^8)
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ p;
            end
            p = gf_xtime(p);
        end
        return acc;
    endfunction

endpackage

//--- hdl/aes_sbox.sv
`timescale 1ns/1ps

module aes_sbox (
    input  logic [7:0] in,
    input  logic       inv,   // High selects the inverse S-box
    output logic [7:0] out
);

    logic [7:0] lin_in;
    logic [7:0] recip;

    function automatic logic [7:0] rotl8(input logic [7:0] a, input int n);
        return (a << n) | (a >> (8 - n));
    endfunction

    // a^254, which is also the inverse for a nonzero a and maps 0 to 0
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = aes_pkg::gf_mul(sq, sq);    // a^(2^i)
            acc = aes_pkg::gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // Forward affine map
    function automatic logic [7:0] affine_fwd(input logic [7:0] a);
        logic [7:0] r;
        r = a ^ rotl8(a, 1) ^ rotl8(a, 2) ^ rotl8(a, 3) ^ rotl8(a, 4);
        return r ^ aes_pkg::sbox_affine_c;
    endfunction

    // Inverse affine map, constant removed before the linear part
    function automatic logic [7:0] affine_inv(input logic [7:0] a);
        logic [7:0] s;
        s = a ^ aes_pkg::sbox_affine_c;
        return rotl8(s, 1) ^ rotl8(s, 3) ^ rotl8(s, 6);
    endfunction

    // One shared inversion for both directions
    always_comb begin
        lin_in = inv ? affine_inv(in) : in;
        recip  = gf_inv(lin_in);
        out    = inv ? recip : affine_fwd(recip);
    end

endmodule

//--- hdl/cop_aes.sv
`timescale 1ns/1ps

module cop_aes (
    input  logic                                g_clk,
    input  logic                                g_resetn,
    input  logic                                aes_ivalid,    // Level, held until done
    input  logic [aes_pkg::data_w-1:0]          aes_rs1,
    input  logic [aes_pkg::data_w-1:0]          aes_rs2,
    input  logic [cop_isa_pkg::class_w-1:0]     id_class,
    input  logic [cop_isa_pkg::subclass_w-1:0]  id_subclass,
    output logic                                aes_idone,
    output logic [aes_pkg::data_w/8-1:0]        aes_cpr_rd_ben,
    output logic [aes_pkg::data_w-1:0]          aes_cpr_rd_wdata
);

    logic                       aes_run;
    logic                       sub_enc;
    logic                       sub_encrot;
    logic                       sub_dec;
    logic                       sub_decrot;
    logic                       mix_enc;
    logic                       mix_dec;
    logic                       sub_instr;
    logic                       mix_instr;
    logic                       mode_dec;
    logic                       rotate;
    logic [1:0]                 seq;
    logic [aes_pkg::data_w-1:0] src_word;
    logic [aes_pkg::data_w-1:0] mix_col;
    logic [aes_pkg::data_w-1:0] part_q;
    logic [7:0]                 sbox_in;
    logic [7:0]                 sbox_out;
    logic [7:0]                 mix_out;
    logic [7:0]                 step_byte;
    logic [1:0]                 step_lane;

    // Byte k of a MixColumns column, coefficient row rotated by k
    function automatic logic [7:0] mix_byte(input logic [aes_pkg::data_w-1:0] col,
                                            input logic [1:0] step,
                                            input logic inv);
        logic [15:0] coef;
        logic [1:0]  lane;
        logic [7:0]  acc;
        coef = inv ? {aes_pkg::mix_inv_c3, aes_pkg::mix_inv_c2,
                      aes_pkg::mix_inv_c1, aes_pkg::mix_inv_c0}
                   : {4'h1, 4'h1, 4'h3, 4'h2};
        acc  = 8'h00;
        for (int j = 0; j < 4; j++) begin
            lane = step + 2'(j);
            acc  = acc ^ aes_pkg::gf_mul(col[8*lane +: 8], {4'h0, coef[4*j +: 4]});
        end
        return acc;
    endfunction

    assign aes_run = aes_ivalid && (id_class == cop_isa_pkg::class_aes);

    assign sub_enc    = aes_run && (id_subclass == cop_isa_pkg::sclass_sub_enc);
    assign sub_encrot = aes_run && (id_subclass == cop_isa_pkg::sclass_sub_encrot);
    assign sub_dec    = aes_run && (id_subclass == cop_isa_pkg::sclass_sub_dec);
    assign sub_decrot = aes_run && (id_subclass == cop_isa_pkg::sclass_sub_decrot);
    assign mix_enc    = aes_run && (id_subclass == cop_isa_pkg::sclass_mix_enc);
    assign mix_dec    = aes_run && (id_subclass == cop_isa_pkg::sclass_mix_dec);

    assign sub_instr = sub_enc || sub_encrot || sub_dec || sub_decrot;
    assign mix_instr = mix_enc || mix_dec;
    assign mode_dec  = sub_dec || sub_decrot || mix_dec;
    assign rotate    = sub_encrot || sub_decrot;

    // Byte sequencer, wraps to 0 on the writeback edge
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            seq <= 2'd0;
        end else if (sub_instr || mix_instr) begin
            seq <= seq + 2'd1;
        end
    end

    assign aes_idone      = (sub_instr || mix_instr) && (seq == 2'd3);
    assign aes_cpr_rd_ben = {4{aes_idone}};

    // Even steps read rs1, odd steps rs2
    assign src_word = seq[0] ? aes_rs2 : aes_rs1;
    assign sbox_in  = src_word[8*seq +: 8];

    aes_sbox u_sbox (
        .in  (sbox_in),
        .inv (mode_dec),
        .out (sbox_out)
    );

    // t0,t1 from rs1 and t2,t3 from rs2
    assign mix_col = {aes_rs2[31:16], aes_rs1[15:0]};
    assign mix_out = mix_byte(mix_col, seq, mode_dec);

    assign step_byte = sub_instr ? sbox_out : mix_out;
    assign step_lane = seq + {1'b0, rotate};   // Rotate moves one lane up

    // Partial result, one lane per step
    always_ff @(posedge g_clk) begin
        if (sub_instr || mix_instr) begin
            part_q[8*step_lane +: 8] <= step_byte;
        end
    end

    // Last byte bypasses the partial register
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (step_lane == 2'(b)) begin
                aes_cpr_rd_wdata[8*b +: 8] = step_byte;
            end else begin
                aes_cpr_rd_wdata[8*b +: 8] = part_q[8*b +: 8];
            end
        end
    end

endmodule

//--- hdl/cop_decode.sv
`timescale 1ns/1ps

module cop_decode (
    input  logic                                g_clk,
    input  logic                                g_resetn,
    input  logic                                instr_valid,   // Strobe, ignored while busy
    input  logic [cop_isa_pkg::instr_w-1:0]     instr,
    output logic                                busy,
    output logic                                illegal,
    output logic                                aes_ivalid,
    output logic [cop_isa_pkg::class_w-1:0]     id_class,
    output logic [cop_isa_pkg::subclass_w-1:0]  id_subclass,
    output logic [cop_isa_pkg::reg_idx_w-1:0]   rs1_idx,
    output logic [cop_isa_pkg::reg_idx_w-1:0]   rs2_idx,
    output logic [cop_isa_pkg::reg_idx_w-1:0]   rd_idx,
    input  logic                                aes_idone
);

    logic [cop_isa_pkg::class_w-1:0]    in_class;
    logic [cop_isa_pkg::subclass_w-1:0] in_subclass;
    logic                               accept;
    logic                               legal;

    function automatic logic known_subclass(input logic [cop_isa_pkg::subclass_w-1:0] sc);
        case (sc)
            cop_isa_pkg::sclass_sub_enc,
            cop_isa_pkg::sclass_sub_encrot,
            cop_isa_pkg::sclass_sub_dec,
            cop_isa_pkg::sclass_sub_decrot,
            cop_isa_pkg::sclass_mix_enc,
            cop_isa_pkg::sclass_mix_dec: known_subclass = 1'b1;
            default:                     known_subclass = 1'b0;
        endcase
    endfunction

    assign in_class    = instr[cop_isa_pkg::class_lsb +: cop_isa_pkg::class_w];
    assign in_subclass = instr[cop_isa_pkg::subclass_lsb +: cop_isa_pkg::subclass_w];

    assign accept = instr_valid && !busy;
    assign legal  = (in_class == cop_isa_pkg::class_aes) && known_subclass(in_subclass);

    // One instruction in flight, released by the AES done strobe
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            illegal <= accept && !legal;   // Single cycle pulse
            if (accept && legal) begin
                busy <= 1'b1;
            end else if (aes_idone) begin
                busy <= 1'b0;
            end
        end
    end

    // Fields held stable for the whole execution
    always_ff @(posedge g_clk) begin
        if (accept) begin
            id_class    <= in_class;
            id_subclass <= in_subclass;
            rd_idx      <= instr[cop_isa_pkg::rd_lsb  +: cop_isa_pkg::reg_idx_w];
            rs1_idx     <= instr[cop_isa_pkg::rs1_lsb +: cop_isa_pkg::reg_idx_w];
            rs2_idx     <= instr[cop_isa_pkg::rs2_lsb +: cop_isa_pkg::reg_idx_w];
        end
    end

    assign aes_ivalid = busy;

endmodule

//--- hdl/cop_regfile.sv
`timescale 1ns/1ps

module cop_regfile (
    input  logic                              g_clk,
    input  logic                              g_resetn,
    input  logic                              host_wen,
    input  logic [cop_isa_pkg::reg_idx_w-1:0] host_waddr,
    input  logic [aes_pkg::data_w-1:0]        host_wdata,
    input  logic [cop_isa_pkg::reg_idx_w-1:0] host_raddr,
    input  logic [cop_isa_pkg::reg_idx_w-1:0] rs1_idx,
    input  logic [cop_isa_pkg::reg_idx_w-1:0] rs2_idx,
    input  logic [cop_isa_pkg::reg_idx_w-1:0] rd_idx,
    input  logic [aes_pkg::data_w/8-1:0]      rd_ben,    // AES writeback lanes
    input  logic [aes_pkg::data_w-1:0]        rd_wdata,
    output logic [aes_pkg::data_w-1:0]        host_rdata,
    output logic [aes_pkg::data_w-1:0]        rs1_data,
    output logic [aes_pkg::data_w-1:0]        rs2_data
);

    logic [aes_pkg::data_w-1:0] regs [cop_isa_pkg::reg_count];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < cop_isa_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < cop_isa_pkg::reg_count; i++) begin
                for (int b = 0; b < aes_pkg::data_w / 8; b++) begin
                    // AES lane wins over a host write to the same register
                    if (rd_ben[b] && (rd_idx == cop_isa_pkg::reg_idx_w'(i))) begin
                        regs[i][8*b +: 8] <= rd_wdata[8*b +: 8];
                    end else if (host_wen && (host_waddr == cop_isa_pkg::reg_idx_w'(i))) begin
                        regs[i][8*b +: 8] <= host_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Combinational read ports
    assign host_rdata = regs[host_raddr];
    assign rs1_data   = regs[rs1_idx];
    assign rs2_data   = regs[rs2_idx];

endmodule

//--- hdl/cop_top.sv
`timescale 1ns/1ps

module cop_top (
    input  logic                              g_clk,
    input  logic                              g_resetn,
    input  logic                              instr_valid,
    input  logic [cop_isa_pkg::instr_w-1:0]   instr,
    input  logic                              host_wen,
    input  logic [cop_isa_pkg::reg_idx_w-1:0] host_waddr,
    input  logic [aes_pkg::data_w-1:0]        host_wdata,
    input  logic [cop_isa_pkg::reg_idx_w-1:0] host_raddr,
    output logic                              busy,
    output logic                              done,
    output logic                              illegal,
    output logic [aes_pkg::data_w-1:0]        host_rdata
);

    logic                                aes_ivalid;
    logic                                aes_idone;
    logic [cop_isa_pkg::class_w-1:0]     id_class;
    logic [cop_isa_pkg::subclass_w-1:0]  id_subclass;
    logic [cop_isa_pkg::reg_idx_w-1:0]   rs1_idx;
    logic [cop_isa_pkg::reg_idx_w-1:0]   rs2_idx;
    logic [cop_isa_pkg::reg_idx_w-1:0]   rd_idx;
    logic [aes_pkg::data_w-1:0]          rs1_data;
    logic [aes_pkg::data_w-1:0]          rs2_data;
    logic [aes_pkg::data_w/8-1:0]        rd_ben;
    logic [aes_pkg::data_w-1:0]          rd_wdata;

    cop_decode u_decode (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .illegal     (illegal),
        .aes_ivalid  (aes_ivalid),
        .id_class    (id_class),
        .id_subclass (id_subclass),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rd_idx      (rd_idx),
        .aes_idone   (aes_idone)
    );

    cop_aes u_aes (
        .g_clk            (g_clk),
        .g_resetn         (g_resetn),
        .aes_ivalid       (aes_ivalid),
        .aes_rs1          (rs1_data),
        .aes_rs2          (rs2_data),
        .id_class         (id_class),
        .id_subclass      (id_subclass),
        .aes_idone        (aes_idone),
        .aes_cpr_rd_ben   (rd_ben),
        .aes_cpr_rd_wdata (rd_wdata)
    );

    cop_regfile u_regfile (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .host_wen   (host_wen),
        .host_waddr (host_waddr),
        .host_wdata (host_wdata),
        .host_raddr (host_raddr),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rd_idx     (rd_idx),
        .rd_ben     (rd_ben),
        .rd_wdata   (rd_wdata),
        .host_rdata (host_rdata),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    assign done = aes_idone;   // Cycle before the writeback edge

endmodule

//--- testbench/tb_aes_model.svh
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// Substitution tables, filled once before the first test
logic [7:0] sbox_tab [256];
logic [7:0] inv_sbox_tab [256];

function automatic logic [7:0] xtime(input logic [7:0] a);
    return a[7] ? ((a << 1) ^ aes_pkg::gf_poly) : (a << 1);
endfunction

// Multiply by walking the bits of b from the bottom
function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] r;
    x = a;
    y = b;
    r = 8'h00;
    while (y != 8'h00) begin
        if (y[0]) begin
            r = r ^ x;
        end
        x = xtime(x);
        y = y >> 1;
    end
    return r;
endfunction

// Inverse found by search, then the affine matrix row by row
task automatic build_sbox_tables();
    logic [7:0] recip;
    logic [7:0] s;
    logic [2:0] k;
    for (int x = 0; x < 256; x++) begin
        recip = 8'h00;
        for (int c = 1; c < 256; c++) begin
            if (gmul(8'(x), 8'(c)) == 8'h01) begin
                recip = 8'(c);
            end
        end
        for (int i = 0; i < 8; i++) begin
            k = 3'(i);
            s[k] = recip[k] ^ recip[k + 3'd4] ^ recip[k + 3'd5] ^ recip[k + 3'd6]
                   ^ recip[k + 3'd7] ^ aes_pkg::sbox_affine_c[k];
        end
        sbox_tab[x]     = s;
        inv_sbox_tab[s] = 8'(x);
    end
endtask

// SubBytes sources alternate rs1 and rs2, byte k from step k
function automatic logic [31:0] sub_result(input logic [31:0] rs1, input logic [31:0] rs2,
                                           input logic dec, input logic rot);
    logic [31:0] src;
    logic [31:0] res;
    logic [1:0]  lane;
    src = {rs2[31:24], rs1[23:16], rs2[15:8], rs1[7:0]};
    res = '0;
    for (int k = 0; k < 4; k++) begin
        lane = 2'(k) + {1'b0, rot};   // Byte 3 wraps to lane 0
        res[8*lane +: 8] = dec ? inv_sbox_tab[src[8*k +: 8]] : sbox_tab[src[8*k +: 8]];
    end
    return res;
endfunction

function automatic logic [31:0] mix_result(input logic [31:0] rs1, input logic [31:0] rs2,
                                           input logic dec);
    logic [7:0]  t [4];
    logic [7:0]  row [4];
    logic [1:0]  idx;
    logic [31:0] res;
    t[0] = rs1[7:0];
    t[1] = rs1[15:8];
    t[2] = rs2[23:16];
    t[3] = rs2[31:24];
    row[0] = dec ? {4'h0, aes_pkg::mix_inv_c0} : 8'h02;
    row[1] = dec ? {4'h0, aes_pkg::mix_inv_c1} : 8'h03;
    row[2] = dec ? {4'h0, aes_pkg::mix_inv_c2} : 8'h01;
    row[3] = dec ? {4'h0, aes_pkg::mix_inv_c3} : 8'h01;
    res = '0;
    for (int k = 0; k < 4; k++) begin
        for (int j = 0; j < 4; j++) begin
            idx = 2'(k + j);
            res[8*k +: 8] = res[8*k +: 8] ^ gmul(row[j], t[idx]);
        end
    end
    return res;
endfunction

`endif

//--- testbench/tb_cop_top.sv
`timescale 1ns/1ps

module tb_cop_top;

    localparam int rand_pairs = 20;
    localparam int rot_pairs  = 8;
    // Three SubBytes per pair, two rotated, two MixColumns plus one, two timing, two illegal
    localparam int n_instr     = 3 * rand_pairs + 2 * rot_pairs + 2 * rand_pairs + 5;
    localparam int cycle_limit = 40 * n_instr + 200;
    localparam int wait_limit  = 16;
    localparam logic [31:0] guard = 32'hc0ffee11;

    logic        g_clk = 1'b0;
    logic        g_resetn;
    logic        instr_valid;
    logic [31:0] instr;
    logic        host_wen;
    logic [3:0]  host_waddr;
    logic [31:0] host_wdata;
    logic [3:0]  host_raddr;
    logic        busy;
    logic        done;
    logic        illegal;
    logic [31:0] host_rdata;

    int seed        = 32'h0386d535;
    int checks      = 0;
    int errors      = 0;
    int cycle_count = 0;

    cop_top u_cop_top (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .host_wen    (host_wen),
        .host_waddr  (host_waddr),
        .host_wdata  (host_wdata),
        .host_raddr  (host_raddr),
        .busy        (busy),
        .done        (done),
        .illegal     (illegal),
        .host_rdata  (host_rdata)
    );

    `include "tb_aes_model.svh"

    always #2 g_clk = ~g_clk;

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, a test did not finish", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    function automatic logic [31:0] encode(input logic [3:0] cls, input logic [4:0] sc,
                                           input logic [3:0] rd, input logic [3:0] rs1,
                                           input logic [3:0] rs2);
        logic [31:0] w;
        w = '0;
        w[cop_isa_pkg::class_lsb +: cop_isa_pkg::class_w]       = cls;
        w[cop_isa_pkg::subclass_lsb +: cop_isa_pkg::subclass_w] = sc;
        w[cop_isa_pkg::rd_lsb +: cop_isa_pkg::reg_idx_w]        = rd;
        w[cop_isa_pkg::rs1_lsb +: cop_isa_pkg::reg_idx_w]       = rs1;
        w[cop_isa_pkg::rs2_lsb +: cop_isa_pkg::reg_idx_w]       = rs2;
        return w;
    endfunction

    task automatic load_reg(input logic [3:0] idx, input logic [31:0] val);
        @(posedge g_clk);
        host_wen   <= 1'b1;
        host_waddr <= idx;
        host_wdata <= val;
        @(posedge g_clk);   // Write edge
        host_wen <= 1'b0;
    endtask

    task automatic fetch_reg(input logic [3:0] idx, output logic [31:0] val);
        @(posedge g_clk);
        host_raddr <= idx;
        @(negedge g_clk);
        val = host_rdata;
    endtask

    // Strobe one instruction, then count cycles until done or illegal
    task automatic issue(input logic [31:0] word, output int cycles,
                         output logic saw_done, output logic saw_illegal);
        @(posedge g_clk);
        instr_valid <= 1'b1;
        instr       <= word;
        @(posedge g_clk);   // Acceptance edge
        instr_valid <= 1'b0;
        cycles      = 0;
        saw_done    = 1'b0;
        saw_illegal = 1'b0;
        while (!saw_done && !saw_illegal && cycles < wait_limit) begin
            @(negedge g_clk);
            cycles++;
            saw_done    = done;
            saw_illegal = illegal;
        end
    endtask

    task automatic exec_check(input logic [31:0] word, input logic [3:0] rd,
                              input logic [31:0] exp, input string name);
        int          cycles;
        logic        saw_done;
        logic        saw_illegal;
        logic [31:0] got;
        issue(word, cycles, saw_done, saw_illegal);
        require(saw_done && !saw_illegal && cycles == 4,
                {"No done pulse in the fourth cycle for ", name});
        fetch_reg(rd, got);
        compare({"host_rdata ", name}, exp, got);
    endtask

    task automatic run_aes(input logic [4:0] sc, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] exp, input string name);
        load_reg(4'd1, a);
        load_reg(4'd2, b);
        exec_check(encode(cop_isa_pkg::class_aes, sc, 4'd3, 4'd1, 4'd2), 4'd3, exp, name);
    endtask

    task automatic reset_values();
        logic [31:0] got;
        @(negedge g_clk);
        require(!busy && !done && !illegal, "busy, done or illegal not low after reset");
        for (int r = 0; r < 16; r++) begin
            fetch_reg(4'(r), got);
            compare("host_rdata reset", 32'h0, got);
        end
    endtask

    task automatic subbytes_random();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < rand_pairs; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_aes(cop_isa_pkg::sclass_sub_enc, a, b, sub_result(a, b, 1'b0, 1'b0), "sub_enc");
            // Encrypt result as both sources gives back the source bytes in order
            exec_check(encode(cop_isa_pkg::class_aes, cop_isa_pkg::sclass_sub_dec,
                              4'd4, 4'd3, 4'd3), 4'd4,
                       {b[31:24], a[23:16], b[15:8], a[7:0]}, "sub_dec_restore");
            run_aes(cop_isa_pkg::sclass_sub_dec, a, b, sub_result(a, b, 1'b1, 1'b0), "sub_dec");
        end
    endtask

    task automatic rotated_subbytes();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < rot_pairs; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_aes(cop_isa_pkg::sclass_sub_encrot, a, b, sub_result(a, b, 1'b0, 1'b1),
                    "sub_encrot");
            run_aes(cop_isa_pkg::sclass_sub_decrot, a, b, sub_result(a, b, 1'b1, 1'b1),
                    "sub_decrot");
        end
    endtask

    task automatic mixcolumns_random();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < rand_pairs; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_aes(cop_isa_pkg::sclass_mix_enc, a, b, mix_result(a, b, 1'b0), "mix_enc");
            run_aes(cop_isa_pkg::sclass_mix_dec, a, b, mix_result(a, b, 1'b1), "mix_dec");
        end
        // Known column db,13,53,45
        compare("mix_result known column", 32'hbca14d8e,
                mix_result(32'h000013db, 32'h45530000, 1'b0));
        run_aes(cop_isa_pkg::sclass_mix_enc, 32'h000013db, 32'h45530000, 32'hbca14d8e,
                "mix_enc_known");
    endtask

    task automatic busy_timing();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        int          done_count;
        int          done_cycle;
        logic        busy_at_done;
        logic        busy_after;
        a = $random(seed);
        b = $random(seed);
        load_reg(4'd1, a);
        load_reg(4'd2, b);
        load_reg(4'd5, guard);
        done_count   = 0;
        done_cycle   = 0;
        busy_at_done = 1'b0;
        busy_after   = 1'b1;
        @(posedge g_clk);
        instr_valid <= 1'b1;
        instr       <= encode(cop_isa_pkg::class_aes, cop_isa_pkg::sclass_sub_enc,
                              4'd3, 4'd1, 4'd2);
        @(posedge g_clk);   // Accepted here, second strobe held while busy
        instr <= encode(cop_isa_pkg::class_aes, cop_isa_pkg::sclass_mix_enc, 4'd5, 4'd1, 4'd2);
        for (int c = 1; c <= 6; c++) begin
            @(negedge g_clk);
            if (done) begin
                done_count++;
                done_cycle   = c;
                busy_at_done = busy;
            end
            if (c == 5) begin
                busy_after = busy;
            end
            @(posedge g_clk);
            if (c == 2) begin
                instr_valid <= 1'b0;
            end
        end
        compare("done_count", 32'd1, 32'(done_count));
        require(done_cycle == 4, "done did not come in the fourth cycle after acceptance");
        require(busy_at_done && !busy_after, "busy did not fall right after done");
        fetch_reg(4'd3, got);
        compare("host_rdata timing", sub_result(a, b, 1'b0, 1'b0), got);
        fetch_reg(4'd5, got);
        compare("host_rdata ignored", guard, got);
    endtask

    task automatic illegal_rejects();
        int          cycles;
        logic        saw_done;
        logic        saw_illegal;
        logic [31:0] got;
        logic [31:0] words [2];
        words[0] = encode(4'h3, cop_isa_pkg::sclass_sub_enc, 4'd3, 4'd1, 4'd2);   // Not AES
        words[1] = encode(cop_isa_pkg::class_aes, 5'h1f, 4'd3, 4'd1, 4'd2);
        load_reg(4'd3, guard);
        for (int i = 0; i < 2; i++) begin
            issue(words[i], cycles, saw_done, saw_illegal);
            require(saw_illegal && cycles == 1, "No illegal pulse after a bad instruction");
            for (int c = 0; c < 6; c++) begin
                @(negedge g_clk);
                saw_done = saw_done | done;
            end
            require(!saw_done && !busy, "Bad instruction started execution");
            fetch_reg(4'd3, got);
            compare("host_rdata illegal", guard, got);
        end
    endtask

    initial begin
        g_resetn    = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        host_wen    = 1'b0;
        host_waddr  = '0;
        host_wdata  = '0;
        host_raddr  = '0;
        build_sbox_tables();
        repeat (4) @(posedge g_clk);
        g_resetn <= 1'b1;
        reset_values();
        subbytes_random();
        rotated_subbytes();
        mixcolumns_random();
        busy_timing();
        illegal_rejects();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+testbench
hdl/cop_isa_pkg.sv
hdl/aes_pkg.sv
hdl/aes_sbox.sv
hdl/cop_aes.sv
hdl/cop_decode.sv
hdl/cop_regfile.sv
hdl/cop_top.sv
testbench/tb_cop_top.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_cop_top \
    -Mdir obj_dir -o sim_cop_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cop_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
